// ==== src.f ====
rtl/hartPkg.sv
rtl/gprFile.sv
rtl/csrFile.sv
rtl/trapCtrl.sv
rtl/dbgAxiSlave.sv
rtl/hartState.sv
verif/hartStateTb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the testbench, pass or fail comes from the log
rm -f sim.log
verilator --binary --timing -Wno-fatal --top-module hartStateTb -f src.f -o hartStateSim \
  && ./obj_dir/hartStateSim > sim.log 2>&1
grep -q "All checks passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

// ==== verif/hartStateTb.sv ====
module hartStateTb
  import hartPkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int regNum = 32;
  localparam int timeoutCycles = 50;

  logic clk;
  logic rst;
  logic gprWen;
  logic [4:0] gprWaddr;
  xlenT gprWdata;
  logic [4:0] rs1Addr;
  xlenT rs1Data;
  logic [4:0] rs2Addr;
  xlenT rs2Data;
  logic csrWen;
  csrAddrT csrWaddr;
  xlenT csrWdata;
  csrAddrT csrRaddr;
  xlenT csrRdata;
  logic trapReq;
  causeT trapCause;
  xlenT trapPc;
  logic mretReq;
  logic redirectValid;
  xlenT redirectPc;
  logic awvalid;
  logic awready;
  dbgAddrT awaddr;
  logic wvalid;
  logic wready;
  xlenT wdata;
  logic [7:0] wstrb;
  logic bvalid;
  logic bready;
  axiRespT bresp;
  logic arvalid;
  logic arready;
  dbgAddrT araddr;
  logic rvalid;
  logic rready;
  xlenT rdata;
  axiRespT rresp;

  // shadow of the architectural state
  xlenT gprM [regNum];
  xlenT mstatusM;
  xlenT mtvecM;
  xlenT mepcM;
  causeT mcauseM;
  xlenT expPcQ [$];
  int checks;
  int errors;

  hartState #(
    .regNum(regNum)
  ) i_dut (.*);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  task automatic checkData(input string name, input xlenT exp, input xlenT act);
    checks++;
    if (act !== exp) begin
      $display("CHECK FAILED %s expected %h actual %h", name, exp, act);
      errors++;
    end
  endtask

  task automatic checkResp(input string name, input axiRespT exp, input axiRespT act);
    checks++;
    if (act !== exp) begin
      $display("CHECK FAILED %s expected %h actual %h", name, exp, act);
      errors++;
    end
  endtask

  task automatic checkPc(input string name, input xlenT exp, input xlenT act);
    checks++;
    if (act !== exp) begin
      $display("CHECK FAILED %s expected %h actual %h", name, exp, act);
      errors++;
    end
  endtask

  task automatic reportProblem(input string what);
    $display("%s", what);
    errors++;
  endtask

  function automatic dbgAddrT csrDbgAddr(input csrAddrT num);
    return {1'b1, num, 3'b000};
  endfunction

  function automatic dbgAddrT gprDbgAddr(input logic [4:0] idx);
    return {8'h00, idx, 3'b000};
  endfunction

  function automatic axiRespT modelRead(input dbgAddrT addr, output xlenT data);
    int idx;
    data = '0;
    if (!addr[15]) begin
      idx = int'(addr[7:3]);
      if (idx >= regNum) begin
        return RESP_SLVERR;
      end
      data = gprM[idx];
      return RESP_OKAY;
    end
    case (csrAddrT'(addr[14:3]))
      CSR_MSTATUS: data = mstatusM;
      CSR_MTVEC:   data = mtvecM;
      CSR_MEPC:    data = mepcM;
      CSR_MCAUSE:  data = mcauseM;
      default:     return RESP_SLVERR;
    endcase
    return RESP_OKAY;
  endfunction

  function automatic axiRespT modelWrite(input dbgAddrT addr, input xlenT data);
    xlenT old;
    axiRespT resp;
    resp = modelRead(addr, old);
    if (resp == RESP_OKAY) begin
      if (!addr[15]) begin
        // x0 stays zero
        if (addr[7:3] != 5'd0) begin
          gprM[addr[7:3]] = data;
        end
      end else begin
        case (csrAddrT'(addr[14:3]))
          CSR_MSTATUS: mstatusM = data;
          CSR_MTVEC:   mtvecM = data;
          CSR_MEPC:    mepcM = data;
          default:     mcauseM = data;
        endcase
      end
    end
    return resp;
  endfunction

  function automatic xlenT modelTrap(input causeT cause, input xlenT pc);
    mepcM = pc;
    mcauseM = cause;
    mstatusM[MSTATUS_MPIE] = mstatusM[MSTATUS_MIE];
    mstatusM[MSTATUS_MIE] = 1'b0;
    // direct mode, low two bits are the mode field
    return {mtvecM[63:2], 2'b00};
  endfunction

  function automatic xlenT modelMret();
    mstatusM[MSTATUS_MIE] = mstatusM[MSTATUS_MPIE];
    mstatusM[MSTATUS_MPIE] = 1'b1;
    return mepcM;
  endfunction

  function automatic dbgAddrT randAddr();
    int sel;
    sel = $urandom_range(0, 9);
    case (sel)
      5:       return csrDbgAddr(CSR_MSTATUS);
      6:       return csrDbgAddr(CSR_MTVEC);
      7:       return csrDbgAddr(CSR_MEPC);
      8:       return csrDbgAddr(CSR_MCAUSE);
      // unimplemented CSR numbers
      9:       return csrDbgAddr(12'h7b0 + 12'($urandom_range(0, 15)));
      default: return gprDbgAddr(5'($urandom_range(0, 31)));
    endcase
  endfunction

  task automatic dbgWrite(input dbgAddrT addr, input xlenT data, input int hold,
                          output axiRespT resp);
    int n;
    @(negedge clk);
    awaddr = addr;
    wdata = data;
    awvalid = 1'b1;
    wvalid = 1'b1;
    #1;
    n = 0;
    while (!(awready && wready) && n < timeoutCycles) begin
      @(negedge clk);
      #1;
      n++;
    end
    if (n == timeoutCycles) begin
      reportProblem("timeout waiting for awready and wready");
    end
    @(negedge clk);
    awvalid = 1'b0;
    wvalid = 1'b0;
    #1;
    n = 0;
    while (!bvalid && n < timeoutCycles) begin
      @(negedge clk);
      #1;
      n++;
    end
    if (n == timeoutCycles) begin
      reportProblem("timeout waiting for bvalid");
    end
    resp = bresp;
    // offer a second write while the response is stalled
    repeat (hold) begin
      @(negedge clk);
      awvalid = 1'b1;
      wvalid = 1'b1;
      #1;
      if (awready || wready || !bvalid) begin
        reportProblem("write handshake changed while bready was low");
      end
      checkResp("bresp held", resp, bresp);
    end
    @(negedge clk);
    awvalid = 1'b0;
    wvalid = 1'b0;
    bready = 1'b1;
    @(negedge clk);
    bready = 1'b0;
  endtask

  task automatic dbgRead(input dbgAddrT addr, input int hold, output xlenT data,
                         output axiRespT resp);
    int n;
    @(negedge clk);
    araddr = addr;
    arvalid = 1'b1;
    #1;
    n = 0;
    while (!arready && n < timeoutCycles) begin
      @(negedge clk);
      #1;
      n++;
    end
    if (n == timeoutCycles) begin
      reportProblem("timeout waiting for arready");
    end
    @(negedge clk);
    arvalid = 1'b0;
    #1;
    n = 0;
    while (!rvalid && n < timeoutCycles) begin
      @(negedge clk);
      #1;
      n++;
    end
    if (n == timeoutCycles) begin
      reportProblem("timeout waiting for rvalid");
    end
    data = rdata;
    resp = rresp;
    repeat (hold) begin
      @(negedge clk);
      arvalid = 1'b1;
      #1;
      if (arready || !rvalid) begin
        reportProblem("read handshake changed while rready was low");
      end
      checkData("rdata held", data, rdata);
      checkResp("rresp held", resp, rresp);
    end
    @(negedge clk);
    arvalid = 1'b0;
    rready = 1'b1;
    @(negedge clk);
    rready = 1'b0;
  endtask

  task automatic writeAndCheck(input dbgAddrT addr, input xlenT data, input int hold);
    axiRespT resp;
    dbgWrite(addr, data, hold, resp);
    checkResp($sformatf("write resp %h", addr), modelWrite(addr, data), resp);
  endtask

  task automatic readAndCompare(input dbgAddrT addr, input int hold);
    xlenT data;
    xlenT expData;
    axiRespT resp;
    axiRespT expResp;
    dbgRead(addr, hold, data, resp);
    expResp = modelRead(addr, expData);
    checkResp($sformatf("read resp %h", addr), expResp, resp);
    checkData($sformatf("read data %h", addr), expData, data);
  endtask

  task automatic checkCsrs();
    readAndCompare(csrDbgAddr(CSR_MSTATUS), 0);
    readAndCompare(csrDbgAddr(CSR_MTVEC), 0);
    readAndCompare(csrDbgAddr(CSR_MEPC), 0);
    readAndCompare(csrDbgAddr(CSR_MCAUSE), 0);
  endtask

  task automatic coreCsrWrite(input csrAddrT num, input xlenT data);
    xlenT expData;
    @(negedge clk);
    csrWen = 1'b1;
    csrWaddr = num;
    csrWdata = data;
    void'(modelWrite(csrDbgAddr(num), data));
    @(negedge clk);
    csrWen = 1'b0;
    csrRaddr = num;
    #1;
    void'(modelRead(csrDbgAddr(num), expData));
    checkData("core csr readback", expData, csrRdata);
  endtask

  task automatic coreEvent(input logic doTrap, input logic doMret, input causeT cause,
                           input xlenT pc);
    int n;
    @(negedge clk);
    trapReq = doTrap;
    mretReq = doMret;
    trapCause = cause;
    trapPc = pc;
    // a trap shadows an mret in the same cycle
    if (doTrap) begin
      expPcQ.push_back(modelTrap(cause, pc));
    end else if (doMret) begin
      expPcQ.push_back(modelMret());
    end
    @(negedge clk);
    trapReq = 1'b0;
    mretReq = 1'b0;
    n = 0;
    while (expPcQ.size() != 0 && n < timeoutCycles) begin
      @(negedge clk);
      n++;
    end
    if (expPcQ.size() != 0) begin
      reportProblem("timeout waiting for redirectValid");
      expPcQ.delete();
    end
  endtask

  task automatic contention(input logic [4:0] idx);
    xlenT coreData;
    xlenT dbgData;
    axiRespT resp;
    coreData = {$urandom, $urandom};
    dbgData = {$urandom, $urandom};
    fork
      begin
        @(negedge clk);
        gprWen = 1'b1;
        gprWaddr = idx;
        gprWdata = coreData;
        gprM[idx] = coreData;
        repeat (4) begin
          #1;
          if (awready || wready) begin
            reportProblem("debug write accepted while the core held gprWen");
          end
          @(negedge clk);
        end
        gprWen = 1'b0;
      end
      begin
        dbgWrite(gprDbgAddr(idx), dbgData, 0, resp);
      end
    join
    checkResp("contention write resp", modelWrite(gprDbgAddr(idx), dbgData), resp);
    @(negedge clk);
    rs1Addr = idx;
    #1;
    checkData("contention final value", gprM[idx], rs1Data);
  endtask

  // redirect checker, each request expects exactly one valid cycle
  initial begin
    forever begin
      @(negedge clk);
      #1;
      if (redirectValid) begin
        if (expPcQ.size() == 0) begin
          reportProblem("redirectValid high without a pending trap or mret");
        end else begin
          checkPc("redirect pc", expPcQ.pop_front(), redirectPc);
        end
      end
    end
  end

  initial begin
    dbgAddrT addr;
    logic [4:0] idx;
    logic [4:0] other;
    xlenT data;
    void'($urandom(32'h90d6));
    checks = 0;
    errors = 0;
    rst = 1'b1;
    gprWen = 1'b0;
    gprWaddr = '0;
    gprWdata = '0;
    rs1Addr = '0;
    rs2Addr = '0;
    csrWen = 1'b0;
    csrWaddr = '0;
    csrWdata = '0;
    csrRaddr = '0;
    trapReq = 1'b0;
    trapCause = '0;
    trapPc = '0;
    mretReq = 1'b0;
    awvalid = 1'b0;
    awaddr = '0;
    wvalid = 1'b0;
    wdata = '0;
    wstrb = '1;
    bready = 1'b0;
    arvalid = 1'b0;
    araddr = '0;
    rready = 1'b0;
    for (int i = 0; i < regNum; i++) begin
      gprM[i] = '0;
    end
    mstatusM = '0;
    mtvecM = '0;
    mepcM = '0;
    mcauseM = '0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    #1;
    if (bvalid || rvalid || redirectValid || awready || wready || arready) begin
      reportProblem("handshake or redirect output high after reset");
    end
    checkCsrs();

    // core writes, x0 every eighth round
    for (int i = 0; i < 40; i++) begin
      idx = (i % 8 == 0) ? 5'd0 : 5'($urandom_range(1, 31));
      other = 5'($urandom_range(0, 31));
      data = {$urandom, $urandom};
      @(negedge clk);
      gprWen = 1'b1;
      gprWaddr = idx;
      gprWdata = data;
      if (idx != 5'd0) begin
        gprM[idx] = data;
      end
      @(negedge clk);
      gprWen = 1'b0;
      rs1Addr = idx;
      rs2Addr = other;
      #1;
      checkData("rs1 after write", (idx == 5'd0) ? xlenT'(0) : data, rs1Data);
      checkData("rs2 after write", gprM[other], rs2Data);
    end

    for (int i = 0; i < 30; i++) begin
      addr = randAddr();
      writeAndCheck(addr, {$urandom, $urandom}, 0);
      readAndCompare(addr, 0);
      readAndCompare(randAddr(), 0);
    end
    writeAndCheck(csrDbgAddr(12'h7c0), '1, 0);
    readAndCompare(csrDbgAddr(12'h7c0), 0);
    checkCsrs();
    for (int i = 0; i < regNum; i++) begin
      readAndCompare(gprDbgAddr(5'(i)), 0);
    end

    // trap, mret, then both at once
    coreCsrWrite(CSR_MTVEC, {$urandom, $urandom});
    coreCsrWrite(CSR_MSTATUS, 64'h8);
    for (int i = 0; i < 9; i++) begin
      if (i == 3 || i == 6) begin
        coreCsrWrite(CSR_MSTATUS, {$urandom, $urandom});
      end
      coreEvent(i % 3 != 1, i % 3 != 0, {$urandom, $urandom}, {$urandom, $urandom});
      checkCsrs();
    end

    contention(5'($urandom_range(1, 31)));
    contention(5'($urandom_range(1, 31)));

    for (int i = 0; i < 10; i++) begin
      addr = randAddr();
      writeAndCheck(addr, {$urandom, $urandom}, $urandom_range(1, 5));
      readAndCompare(addr, $urandom_range(1, 5));
    end

    repeat (2) @(negedge clk);
    $display("checks: %0d errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

// ==== rtl/hartState.sv ====
module hartState
  import hartPkg::*;
#(
  parameter int regNum = 32,
  localparam int idxW = $clog2(regNum)
) (
  input  logic            clk,
  input  logic            rst,
  input  logic            gprWen,
  input  logic [idxW-1:0] gprWaddr,
  input  xlenT            gprWdata,
  input  logic [idxW-1:0] rs1Addr,
  output xlenT            rs1Data,
  input  logic [idxW-1:0] rs2Addr,
  output xlenT            rs2Data,
  input  logic            csrWen,
  input  csrAddrT         csrWaddr,
  input  xlenT            csrWdata,
  input  csrAddrT         csrRaddr,
  output xlenT            csrRdata,
  input  logic            trapReq,
  input  causeT           trapCause,
  input  xlenT            trapPc,
  input  logic            mretReq,
  output logic            redirectValid,
  output xlenT            redirectPc,
  input  logic            awvalid,
  output logic            awready,
  input  dbgAddrT         awaddr,
  input  logic            wvalid,
  output logic            wready,
  input  xlenT            wdata,
  input  logic [7:0]      wstrb,
  output logic            bvalid,
  input  logic            bready,
  output axiRespT         bresp,
  input  logic            arvalid,
  output logic            arready,
  input  dbgAddrT         araddr,
  output logic            rvalid,
  input  logic            rready,
  output xlenT            rdata,
  output axiRespT         rresp
);

  logic dbgGprWen;
  logic dbgCsrWen;
  xlenT dbgWdata;
  logic [idxW-1:0] dbgGprIdx;
  csrAddrT dbgCsrAddr;
  xlenT dbgGprRdata;
  xlenT dbgCsrRdata;
  logic dbgCsrHit;
  csrAddrT dbgCsrRaddr;
  logic trapTake;
  logic mretTake;
  xlenT mtvec;
  xlenT mepc;
  logic gprWenMrg;
  logic [idxW-1:0] gprWaddrMrg;
  xlenT gprWdataMrg;
  logic csrWenMrg;
  csrAddrT csrWaddrMrg;
  xlenT csrWdataMrg;

  // core write port wins, debug only fills idle cycles
  assign gprWenMrg = gprWen || (dbgGprWen && !gprWen);
  assign gprWaddrMrg = gprWen ? gprWaddr : dbgGprIdx;
  assign gprWdataMrg = gprWen ? gprWdata : dbgWdata;
  assign csrWenMrg = csrWen || (dbgCsrWen && !csrWen);
  assign csrWaddrMrg = csrWen ? csrWaddr : dbgCsrAddr;
  assign csrWdataMrg = csrWen ? csrWdata : dbgWdata;

  gprFile #(
    .regNum(regNum)
  ) i_gprFile (
    .clk   (clk),
    .rst   (rst),
    .wen   (gprWenMrg),
    .waddr (gprWaddrMrg),
    .wdata (gprWdataMrg),
    .r1Addr(rs1Addr),
    .r1Data(rs1Data),
    .r2Addr(rs2Addr),
    .r2Data(rs2Data),
    .r3Addr(dbgGprIdx),
    .r3Data(dbgGprRdata)
  );

  csrFile i_csrFile (
    .clk      (clk),
    .rst      (rst),
    .wen      (csrWenMrg),
    .waddr    (csrWaddrMrg),
    .wdata    (csrWdataMrg),
    .raddr    (csrRaddr),
    .rdata    (csrRdata),
    .dbgRaddr (dbgCsrRaddr),
    .dbgRdata (dbgCsrRdata),
    .dbgHit   (dbgCsrHit),
    .trapTake (trapTake),
    .mretTake (mretTake),
    .trapCause(trapCause),
    .trapPc   (trapPc),
    .mtvec    (mtvec),
    .mepc     (mepc)
  );

  trapCtrl i_trapCtrl (
    .clk          (clk),
    .rst          (rst),
    .trapReq      (trapReq),
    .mretReq      (mretReq),
    .mtvec        (mtvec),
    .mepc         (mepc),
    .trapTake     (trapTake),
    .mretTake     (mretTake),
    .redirectValid(redirectValid),
    .redirectPc   (redirectPc)
  );

  dbgAxiSlave #(
    .regNum(regNum)
  ) i_dbgAxiSlave (
    .clk        (clk),
    .rst        (rst),
    .awvalid    (awvalid),
    .awready    (awready),
    .awaddr     (awaddr),
    .wvalid     (wvalid),
    .wready     (wready),
    .wdata      (wdata),
    .wstrb      (wstrb),
    .bvalid     (bvalid),
    .bready     (bready),
    .bresp      (bresp),
    .arvalid    (arvalid),
    .arready    (arready),
    .araddr     (araddr),
    .rvalid     (rvalid),
    .rready     (rready),
    .rdata      (rdata),
    .rresp      (rresp),
    .coreGprBusy(gprWen),
    .coreCsrBusy(csrWen),
    .gprWen     (dbgGprWen),
    .gprIdx     (dbgGprIdx),
    .csrWen     (dbgCsrWen),
    .csrAddr    (dbgCsrAddr),
    .wdataOut   (dbgWdata),
    .gprRdata   (dbgGprRdata),
    .csrRdata   (dbgCsrRdata),
    .csrHit     (dbgCsrHit),
    .csrRaddr   (dbgCsrRaddr)
  );

endmodule

// ==== rtl/dbgAxiSlave.sv ====
module dbgAxiSlave
  import hartPkg::*;
#(
  parameter int regNum = 32,
  localparam int idxW = $clog2(regNum)
) (
  input  logic            clk,
  input  logic            rst,
  input  logic            awvalid,
  output logic            awready,
  input  dbgAddrT         awaddr,
  input  logic            wvalid,
  output logic            wready,
  input  xlenT            wdata,
  input  logic [7:0]      wstrb,
  output logic            bvalid,
  input  logic            bready,
  output axiRespT         bresp,
  input  logic            arvalid,
  output logic            arready,
  input  dbgAddrT         araddr,
  output logic            rvalid,
  input  logic            rready,
  output xlenT            rdata,
  output axiRespT         rresp,
  input  logic            coreGprBusy,
  input  logic            coreCsrBusy,
  output logic            gprWen,
  output logic [idxW-1:0] gprIdx,
  output logic            csrWen,
  output csrAddrT         csrAddr,
  output xlenT            wdataOut,
  input  xlenT            gprRdata,
  input  xlenT            csrRdata,
  input  logic            csrHit,
  output csrAddrT         csrRaddr
);

  logic rdAccept;
  logic wrAccept;
  logic coreBusy;
  logic rvalidNext;
  dbgAddrT lookAddr;
  logic lookIsCsr;
  logic [4:0] lookIdx;
  logic lookGprOk;
  logic lookOk;

  assign rdAccept = arvalid && arready;

  // one lookup path into both files, an accepted read owns it
  assign lookAddr = rdAccept ? araddr : awaddr;
  assign lookIsCsr = lookAddr[15];
  assign lookIdx = lookAddr[7:3];
  assign lookGprOk = (lookIdx < regNum);
  assign lookOk = lookIsCsr ? csrHit : lookGprOk;

  assign gprIdx = lookIdx[idxW-1:0];
  assign csrRaddr = lookAddr[14:3];

  // stall while the core drives the same kind of write port
  assign coreBusy = awaddr[15] ? coreCsrBusy : coreGprBusy;
  assign wrAccept = awvalid && wvalid && !bvalid && !rdAccept && !coreBusy;
  assign awready = wrAccept;
  assign wready = wrAccept;

  // wstrb ignored, full 64-bit writes only
  assign wdataOut = wdata;
  assign csrAddr = awaddr[14:3];
  assign gprWen = wrAccept && !lookIsCsr && lookGprOk;
  assign csrWen = wrAccept && lookIsCsr && csrHit;

  always_comb begin
    rvalidNext = rvalid;
    if (rdAccept) begin
      rvalidNext = 1'b1;
    end else if (rvalid && rready) begin
      rvalidNext = 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      bvalid <= 1'b0;
      rvalid <= 1'b0;
      arready <= 1'b0;
    end else begin
      if (wrAccept) begin
        bvalid <= 1'b1;
      end else if (bready) begin
        bvalid <= 1'b0;
      end
      rvalid <= rvalidNext;
      arready <= !rvalidNext;
    end
  end

  // response payload, held until the handshake
  always_ff @(posedge clk) begin
    if (wrAccept) begin
      bresp <= lookOk ? RESP_OKAY : RESP_SLVERR;
    end
    if (rdAccept) begin
      rresp <= lookOk ? RESP_OKAY : RESP_SLVERR;
      if (!lookOk) begin
        rdata <= '0;
      end else begin
        rdata <= lookIsCsr ? csrRdata : gprRdata;
      end
    end
  end

endmodule

// ==== rtl/trapCtrl.sv ====
module trapCtrl
  import hartPkg::*;
(
  input  logic clk,
  input  logic rst,
  input  logic trapReq,
  input  logic mretReq,
  input  xlenT mtvec,
  input  xlenT mepc,
  output logic trapTake,
  output logic mretTake,
  output logic redirectValid,
  output xlenT redirectPc
);

  trapStateT state;
  trapStateT stateNext;

  // a trap shadows an mret in the same cycle
  assign trapTake = trapReq;
  assign mretTake = mretReq && !trapReq;

  always_comb begin
    stateNext = state;
    case (state)
      IDLE: begin
        if (trapTake || mretTake) begin
          stateNext = REDIRECT;
        end
      end
      REDIRECT: begin
        // back to back requests keep the redirect going
        if (!(trapTake || mretTake)) begin
          stateNext = IDLE;
        end
      end
      default: stateNext = IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= IDLE;
    end else begin
      state <= stateNext;
    end
  end

  // direct mode only, base is mtvec with the mode bits cleared
  always_ff @(posedge clk) begin
    if (trapTake) begin
      redirectPc <= {mtvec[63:2], 2'b00};
    end else if (mretTake) begin
      redirectPc <= mepc;
    end
  end

  assign redirectValid = (state == REDIRECT);

endmodule

// ==== rtl/csrFile.sv ====
module csrFile
  import hartPkg::*;
(
  input  logic    clk,
  input  logic    rst,
  input  logic    wen,
  input  csrAddrT waddr,
  input  xlenT    wdata,
  input  csrAddrT raddr,
  output xlenT    rdata,
  input  csrAddrT dbgRaddr,
  output xlenT    dbgRdata,
  output logic    dbgHit,
  input  logic    trapTake,
  input  logic    mretTake,
  input  causeT   trapCause,
  input  xlenT    trapPc,
  output xlenT    mtvec,
  output xlenT    mepc
);

  xlenT mstatus;
  causeT mcause;
  xlenT mstatusNext;

  function automatic xlenT readCsr(input csrAddrT addr);
    xlenT value;
    case (addr)
      CSR_MSTATUS: value = mstatus;
      CSR_MTVEC:   value = mtvec;
      CSR_MEPC:    value = mepc;
      CSR_MCAUSE:  value = mcause;
      default:     value = '0;
    endcase
    return value;
  endfunction

  always_comb begin
    rdata = readCsr(raddr);
    dbgRdata = readCsr(dbgRaddr);
  end

  assign dbgHit = dbgRaddr inside {CSR_MSTATUS, CSR_MTVEC, CSR_MEPC, CSR_MCAUSE};

  // trap and mret bit moves land on top of a plain write
  always_comb begin
    mstatusNext = (wen && waddr == CSR_MSTATUS) ? wdata : mstatus;
    if (trapTake) begin
      mstatusNext[MSTATUS_MPIE] = mstatus[MSTATUS_MIE];
      mstatusNext[MSTATUS_MIE] = 1'b0;
    end else if (mretTake) begin
      mstatusNext[MSTATUS_MIE] = mstatus[MSTATUS_MPIE];
      mstatusNext[MSTATUS_MPIE] = 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      mstatus <= '0;
      mtvec <= '0;
      mepc <= '0;
      mcause <= '0;
    end else begin
      mstatus <= mstatusNext;
      // mode bits are stored but the base is all that is used
      if (wen && waddr == CSR_MTVEC) begin
        mtvec <= wdata;
      end
      if (trapTake) begin
        mepc <= trapPc;
        mcause <= trapCause;
      end else begin
        if (wen && waddr == CSR_MEPC) begin
          mepc <= wdata;
        end
        if (wen && waddr == CSR_MCAUSE) begin
          mcause <= wdata;
        end
      end
    end
  end

endmodule

// ==== rtl/gprFile.sv ====
module gprFile
  import hartPkg::*;
#(
  parameter int regNum = 32,
  localparam int idxW = $clog2(regNum)
) (
  input  logic            clk,
  input  logic            rst,
  input  logic            wen,
  input  logic [idxW-1:0] waddr,
  input  xlenT            wdata,
  input  logic [idxW-1:0] r1Addr,
  output xlenT            r1Data,
  input  logic [idxW-1:0] r2Addr,
  output xlenT            r2Data,
  input  logic [idxW-1:0] r3Addr,
  output xlenT            r3Data
);

  xlenT regs [regNum];

  // x0 is never written so it keeps its reset value
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < regNum; i++) begin
        regs[i] <= '0;
      end
    end else if (wen && waddr != '0) begin
      regs[waddr] <= wdata;
    end
  end

  assign r1Data = regs[r1Addr];
  assign r2Data = regs[r2Addr];

  // debug port
  assign r3Data = regs[r3Addr];

endmodule

// ==== rtl/hartPkg.sv ====
package hartPkg;

  // register width, fixed by the mstatus layout
  typedef logic [63:0] xlenT;

  typedef logic [11:0] csrAddrT;

  typedef logic [63:0] causeT;

  // debugger byte address
  typedef logic [15:0] dbgAddrT;

  typedef logic [1:0] axiRespT;

  localparam axiRespT RESP_OKAY = 2'b00;
  localparam axiRespT RESP_SLVERR = 2'b10;

  // machine CSR numbers
  localparam csrAddrT CSR_MSTATUS = 12'h300;
  localparam csrAddrT CSR_MTVEC = 12'h305;
  localparam csrAddrT CSR_MEPC = 12'h341;
  localparam csrAddrT CSR_MCAUSE = 12'h342;

  // mstatus interrupt enable bits
  localparam int MSTATUS_MIE = 3;
  localparam int MSTATUS_MPIE = 7;

  typedef enum logic {
    IDLE,
    REDIRECT
  } trapStateT;

endpackage
